// File: pkt_capture_golden.txt
# columns: name mode packets data_seed(hex) load load_sec load_nsec, then one byte length per packet
# mode random gives 1-in-3 waitrequest, stall holds waitrequest high while packets are sent
single_4   random 1 a0000000 0 0 0 4
single_5   random 1 a1000000 0 0 0 5
single_64  random 1 a2000000 0 0 0 64
b2b_mixed  random 8 b0000000 0 0 0 12 40 8 64 20 16 28 64
ts_wrap    random 3 c0000000 1 5 999999960 8 8 8
ts_exact   random 2 c1000000 1 100 999999980 4 4
drop_stall stall  6 d0000000 0 0 0 64 64 64 64 64 64
partial    random 4 e0000000 0 0 0 1 6 11 63
after_drop random 2 f0000000 0 0 0 16 33

// File: all.f
pkt_capture_pkg.sv
fifo_port_if.sv
timestamp_counter.sv
word_fifo.sv
rx_packet_framer.sv
burst_writer.sv
pkt_capture_top.sv
avalon_mem_model.sv
tb_pkt_capture.sv

// File: Makefile
SRCS = $(wildcard *.sv)

.PHONY: all run clean

all: obj_dir/Vtb_pkt_capture

obj_dir/Vtb_pkt_capture: $(SRCS) all.f
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_pkt_capture -f all.f

run: obj_dir/Vtb_pkt_capture
	obj_dir/Vtb_pkt_capture > sim.log; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_pkt_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pkt_capture;

    import pkt_capture_pkg::*;

    localparam int          CLK_PERIOD     = 20;
    localparam int          RESET_CYCLES   = 16;
    localparam int          CYCLES_PER_PKT = 200;
    localparam int          MAX_TESTS      = 16;
    localparam int          MAX_PKTS       = 8;
    localparam logic [31:0] BASE_ADDR      = 32'h0000_4000;

    logic               clk;
    logic               reset;
    logic               rx_valid;
    logic               rx_first;
    logic               rx_last;
    logic [2:0]         rx_last_bytes;
    logic [DATA_W-1:0]  rx_data;
    logic               ts_set;
    logic [31:0]        ts_sec_in;
    logic [31:0]        ts_nsec_in;
    logic               force_wait;
    wire  [DATA_W-1:0]  av_address;
    wire  [DATA_W-1:0]  av_writedata;
    wire                av_write;
    wire  [BURST_W-1:0] av_burstcount;
    wire                av_waitrequest;
    wire  [15:0]        drop_count;
    wire                record_done;

    // one entry per line of the golden file
    logic [8*16-1:0] t_name  [MAX_TESTS];
    logic            t_stall [MAX_TESTS];
    int              t_count [MAX_TESTS];
    logic [31:0]     t_seed  [MAX_TESTS];
    int              t_load  [MAX_TESTS];
    logic [31:0]     t_lsec  [MAX_TESTS];
    logic [31:0]     t_lnsec [MAX_TESTS];
    int              t_len   [MAX_TESTS][MAX_PKTS];

    int          n_tests;
    int          total_pkts;
    int          limit_cycles = 0;
    int          errors;
    int          bad_bursts   = 0;
    int          done_count   = 0;
    int          records_exp  = 0;  // records expected since reset
    int          tests_passed;
    logic [31:0] next_addr;        // where the next kept record must land
    logic [31:0] ts_base_sec;
    logic [31:0] ts_base_nsec;
    longint      ts_ref;           // edge at which the counter held the base value
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    pkt_capture_top i_dut (
        .clk              (clk),
        .reset            (reset),
        .i_base_addr      (BASE_ADDR),
        .i_rx_valid       (rx_valid),
        .i_rx_first       (rx_first),
        .i_rx_last        (rx_last),
        .i_rx_last_bytes  (rx_last_bytes),
        .i_rx_data        (rx_data),
        .i_ts_set         (ts_set),
        .i_ts_sec         (ts_sec_in),
        .i_ts_nsec        (ts_nsec_in),
        .o_av_address     (av_address),
        .o_av_writedata   (av_writedata),
        .o_av_write       (av_write),
        .o_av_burstcount  (av_burstcount),
        .i_av_waitrequest (av_waitrequest),
        .o_drop_count     (drop_count),
        .o_record_done    (record_done)
    );

    avalon_mem_model u_mem (
        .clk           (clk),
        .i_force_wait  (force_wait),
        .i_address     (av_address),
        .i_writedata   (av_writedata),
        .i_write       (av_write),
        .i_burstcount  (av_burstcount),
        .o_waitrequest (av_waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (reset) begin
            if (record_done) begin
                done_count++;
            end
            if (av_write && (av_burstcount == '0 || av_burstcount > BURST_W'(BURST_MAX))) begin
                $display("bad burst: burstcount %0d outside 1 to %0d", av_burstcount, BURST_MAX);
                bad_bursts++;
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("Regression failed");
        $finish;
    end

    function automatic longint edge_idx();
        return (longint'($time) - longint'(CLK_PERIOD / 2)) / longint'(CLK_PERIOD);
    endfunction

    // counter value right after the given edge
    function automatic void predict_ts(input longint at_edge, output logic [31:0] sec,
                                       output logic [31:0] nsec);
        longint total;
        total = longint'(ts_base_nsec) + longint'(NS_PER_CYCLE) * (at_edge - ts_ref);
        sec   = ts_base_sec + 32'(total / longint'(NS_PER_SEC));
        nsec  = 32'(total % longint'(NS_PER_SEC));
    endfunction

    function automatic void add_expected(input logic [31:0] word);
        exp_addr.push_back(next_addr);
        exp_data.push_back(word);
        next_addr = next_addr + 32'd4;
    endfunction

    task automatic read_golden();
        int              fd;
        int              n;
        int              len;
        logic [8*16-1:0] tok;
        logic [8*8-1:0]  mode;
        logic [8*160-1:0] rest;
        fd = $fopen("pkt_capture_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open pkt_capture_golden.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == 128'("#")) begin
                n = $fgets(rest, fd);   // skip the comment
            end else if (n_tests < MAX_TESTS) begin
                t_name[n_tests] = tok;
                n = $fscanf(fd, "%s %d %h %d %d %d", mode, t_count[n_tests], t_seed[n_tests],
                            t_load[n_tests], t_lsec[n_tests], t_lnsec[n_tests]);
                t_stall[n_tests] = (mode == 64'("stall"));
                for (int i = 0; i < t_count[n_tests]; i++) begin
                    n = $fscanf(fd, "%d", len);
                    if (i < MAX_PKTS) begin
                        t_len[n_tests][i] = len;
                    end
                end
                if (t_count[n_tests] > MAX_PKTS) begin
                    t_count[n_tests] = MAX_PKTS;
                end
                total_pkts += t_count[n_tests];
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset  <= 1'b1;
        ts_ref  = edge_idx();   // counter leaves zero on the next edge
    endtask

    task automatic run_test(input int t);
        int          err0;
        int          kept;
        int          kept_words;
        int          exp_drops;
        int          words;
        int          wcount;
        logic        keep;
        logic [15:0] drops0;
        logic [31:0] sec;
        logic [31:0] nsec;
        logic [31:0] got;
        err0       = errors + bad_bursts;
        kept       = 0;
        kept_words = 0;
        exp_drops  = 0;
        wcount     = 0;
        sec        = '0;
        nsec       = '0;
        exp_addr.delete();
        exp_data.delete();
        @(negedge clk);
        drops0 = drop_count;
        @(posedge clk);
        force_wait <= t_stall[t];
        if (t_load[t] != 0) begin
            ts_set       <= 1'b1;
            ts_sec_in    <= t_lsec[t];
            ts_nsec_in   <= t_lnsec[t];
            ts_base_sec   = t_lsec[t];
            ts_base_nsec  = t_lnsec[t];
            ts_ref        = edge_idx() + 1;   // load shows one edge later
            @(posedge clk);
            ts_set <= 1'b0;
        end
        for (int p = 0; p < t_count[t]; p++) begin
            words = (t_len[t][p] + 3) / 4;
            // room rule counts every kept word as still queued
            keep  = (kept_words + MAX_PKT_WORDS <= DATA_FIFO_DEPTH) && (kept < DESC_FIFO_DEPTH);
            for (int w = 0; w < words; w++) begin
                @(posedge clk);
                if (w == 0) begin
                    predict_ts(edge_idx(), sec, nsec);
                end
                rx_valid      <= 1'b1;
                rx_first      <= (w == 0);
                rx_last       <= (w == words - 1);
                rx_last_bytes <= 3'(t_len[t][p] - 4 * (words - 1));
                rx_data       <= t_seed[t] + 32'(wcount + w);
            end
            if (keep) begin
                add_expected(sec);
                add_expected(nsec);
                add_expected(32'(t_len[t][p]));
                add_expected(32'(t_len[t][p]));
                for (int w = 0; w < words; w++) begin
                    add_expected(t_seed[t] + 32'(wcount + w));
                end
                kept++;
                kept_words += words;
            end else begin
                exp_drops++;
            end
            wcount += words;
        end
        @(posedge clk);
        rx_valid   <= 1'b0;
        rx_first   <= 1'b0;
        rx_last    <= 1'b0;
        force_wait <= 1'b0;
        records_exp += kept;
        while (done_count < records_exp) begin
            @(posedge clk);
        end
        if (done_count != records_exp) begin
            $display("mismatch %0s: records done expected %0d actual %0d",
                     t_name[t], records_exp, done_count);
            errors++;
        end
        @(negedge clk);
        if (int'(drop_count - drops0) != exp_drops) begin
            $display("mismatch %0s: drops expected %0d actual %0d",
                     t_name[t], exp_drops, int'(drop_count - drops0));
            errors++;
        end
        foreach (exp_addr[i]) begin
            got = u_mem.peek(exp_addr[i]);
            if (got !== exp_data[i]) begin
                $display("mismatch %0s: word at 0x%08h expected 0x%08h actual 0x%08h",
                         t_name[t], exp_addr[i], exp_data[i], got);
                errors++;
            end
        end
        if (errors + bad_bursts == err0) begin
            tests_passed++;
            $display("test %0s: ok, %0d records, %0d dropped", t_name[t], kept, exp_drops);
        end else begin
            $display("test %0s: failed with %0d errors", t_name[t], errors + bad_bursts - err0);
        end
    endtask

    initial begin
        void'($urandom(32'h6906_e293));
        reset         = 1'b0;
        rx_valid      = 1'b0;
        rx_first      = 1'b0;
        rx_last       = 1'b0;
        rx_last_bytes = 3'd4;
        rx_data       = '0;
        ts_set        = 1'b0;
        ts_sec_in     = '0;
        ts_nsec_in    = '0;
        force_wait    = 1'b0;
        errors        = 0;
        tests_passed  = 0;
        n_tests       = 0;
        total_pkts    = 0;
        next_addr     = BASE_ADDR;
        ts_base_sec   = '0;
        ts_base_nsec  = '0;
        ts_ref        = 0;
        read_golden();
        limit_cycles = RESET_CYCLES + CYCLES_PER_PKT * total_pkts;
        release_reset();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_tests, tests_passed, n_tests - tests_passed, errors + bad_bursts);
        if (errors + bad_bursts == 0 && n_tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: avalon_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module avalon_mem_model (
    input  wire                                 clk,
    input  wire                                 i_force_wait,   // hold waitrequest high
    input  wire  [31:0]                         i_address,
    input  wire  [31:0]                         i_writedata,
    input  wire                                 i_write,
    input  wire  [pkt_capture_pkg::BURST_W-1:0] i_burstcount,
    output wire                                 o_waitrequest
);

    logic [31:0]                         mem [logic [31:0]];   // sparse, keyed by byte address
    logic [pkt_capture_pkg::BURST_W-1:0] beat   = '0;          // word index inside the burst
    logic                                wait_q = 1'b1;

    assign o_waitrequest = wait_q;

    always @(posedge clk) begin
        // stall about one cycle in three unless held high
        wait_q <= i_force_wait || ($urandom % 3 == 0);
        if (i_write && !wait_q) begin
            mem[i_address + 32'({beat, 2'b00})] = i_writedata;
            beat <= (beat + 1'b1 == i_burstcount) ? '0 : beat + 1'b1;
        end
    end

    // unwritten words read back as a pattern of their own address
    function automatic logic [31:0] peek(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ 32'hdead_beef;
    endfunction

endmodule

`default_nettype wire

// File: pkt_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_capture_top (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [pkt_capture_pkg::DATA_W-1:0]  i_base_addr,
    // receive port
    input  wire                                 i_rx_valid,
    input  wire                                 i_rx_first,
    input  wire                                 i_rx_last,
    input  wire  [2:0]                          i_rx_last_bytes,
    input  wire  [pkt_capture_pkg::DATA_W-1:0]  i_rx_data,
    // timestamp load
    input  wire                                 i_ts_set,
    input  wire  [31:0]                         i_ts_sec,
    input  wire  [31:0]                         i_ts_nsec,
    // avalon-mm host
    output logic [pkt_capture_pkg::DATA_W-1:0]  o_av_address,
    output logic [pkt_capture_pkg::DATA_W-1:0]  o_av_writedata,
    output logic                                o_av_write,
    output logic [pkt_capture_pkg::BURST_W-1:0] o_av_burstcount,
    input  wire                                 i_av_waitrequest,
    output logic [15:0]                         o_drop_count,
    output logic                                o_record_done
);

    import pkt_capture_pkg::*;

    logic [31:0] ts_sec;
    logic [31:0] ts_nsec;

    fifo_port_if #(.payload_t(logic [DATA_W-1:0]), .DEPTH(DATA_FIFO_DEPTH)) data_if ();
    fifo_port_if #(.payload_t(pkt_desc_t), .DEPTH(DESC_FIFO_DEPTH)) desc_if ();

    timestamp_counter u_ts (
        .clk    (clk),
        .reset  (reset),
        .i_set  (i_ts_set),
        .i_sec  (i_ts_sec),
        .i_nsec (i_ts_nsec),
        .o_sec  (ts_sec),
        .o_nsec (ts_nsec)
    );

    rx_packet_framer u_framer (
        .clk             (clk),
        .reset           (reset),
        .i_rx_valid      (i_rx_valid),
        .i_rx_first      (i_rx_first),
        .i_rx_last       (i_rx_last),
        .i_rx_last_bytes (i_rx_last_bytes),
        .i_rx_data       (i_rx_data),
        .i_sec           (ts_sec),
        .i_nsec          (ts_nsec),
        .data_port       (data_if),
        .desc_port       (desc_if),
        .o_drop_count    (o_drop_count)
    );

    word_fifo #(.payload_t(logic [DATA_W-1:0]), .DEPTH(DATA_FIFO_DEPTH)) u_data_fifo (
        .clk     (clk),
        .reset   (reset),
        .port_if (data_if)
    );

    word_fifo #(.payload_t(pkt_desc_t), .DEPTH(DESC_FIFO_DEPTH)) u_desc_fifo (
        .clk     (clk),
        .reset   (reset),
        .port_if (desc_if)
    );

    burst_writer u_writer (
        .clk              (clk),
        .reset            (reset),
        .i_base_addr      (i_base_addr),
        .data_port        (data_if),
        .desc_port        (desc_if),
        .o_av_address     (o_av_address),
        .o_av_writedata   (o_av_writedata),
        .o_av_write       (o_av_write),
        .o_av_burstcount  (o_av_burstcount),
        .i_av_waitrequest (i_av_waitrequest),
        .o_record_done    (o_record_done)
    );

endmodule

`default_nettype wire

// File: burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_writer (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [pkt_capture_pkg::DATA_W-1:0]  i_base_addr,
    fifo_port_if.reader                         data_port,
    fifo_port_if.reader                         desc_port,
    output logic [pkt_capture_pkg::DATA_W-1:0]  o_av_address,
    output logic [pkt_capture_pkg::DATA_W-1:0]  o_av_writedata,
    output logic                                o_av_write,
    output logic [pkt_capture_pkg::BURST_W-1:0] o_av_burstcount,
    input  wire                                 i_av_waitrequest,
    output logic                                o_record_done
);

    import pkt_capture_pkg::*;

    localparam int HDR_IDX_W = $clog2(HDR_WORDS);

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        DATA
    } state_t;

    state_t               state;
    pkt_desc_t            desc_head;
    pkt_desc_t            desc_q;       // descriptor of the record in flight
    len_t                 rec_words;
    len_t                 rec_left;     // words of the record not yet accepted
    logic [BURST_W-1:0]   burst_left;
    logic [HDR_IDX_W-1:0] hdr_idx;
    logic [DATA_W-1:0]    rec_addr;     // start of the next record
    logic [DATA_W-1:0]    burst_end_addr;
    logic                 desc_pop;
    logic                 word_acc;

    function automatic logic [BURST_W-1:0] burst_size(input len_t words);
        if (words > len_t'(BURST_MAX)) begin
            return BURST_W'(BURST_MAX);
        end
        return BURST_W'(words);
    endfunction

    assign desc_head = desc_port.head;
    // header plus data words, rounded up to whole words
    assign rec_words = len_t'(HDR_WORDS) + ((desc_head.length + len_t'(3)) >> 2);

    assign word_acc       = o_av_write && !i_av_waitrequest;
    assign burst_end_addr = o_av_address + DATA_W'({o_av_burstcount, 2'b00});

    assign desc_pop       = (state == IDLE) && !desc_port.empty;
    assign desc_port.pop  = desc_pop;
    assign data_port.pop  = (state == DATA) && word_acc;   // only on acceptance

    always_comb begin
        if (state == DATA) begin
            o_av_writedata = data_port.head;
        end else begin
            case (hdr_idx)
                2'd0:    o_av_writedata = desc_q.sec;
                2'd1:    o_av_writedata = desc_q.nsec;
                default: o_av_writedata = DATA_W'(desc_q.length);  // length twice
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (desc_pop) begin
            desc_q <= desc_head;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state         <= IDLE;
            o_av_write    <= 1'b0;
            o_record_done <= 1'b0;
            rec_addr      <= i_base_addr;
            rec_left      <= '0;
            burst_left    <= '0;
            hdr_idx       <= '0;
        end else begin
            o_record_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (desc_pop) begin
                        state           <= HEADER;
                        o_av_write      <= 1'b1;
                        o_av_address    <= rec_addr;
                        o_av_burstcount <= burst_size(rec_words);
                        burst_left      <= burst_size(rec_words);
                        rec_left        <= rec_words;
                        hdr_idx         <= '0;
                    end
                end
                default: begin
                    // waitrequest holds everything where it is
                    if (word_acc) begin
                        rec_left   <= rec_left - 1'b1;
                        burst_left <= burst_left - 1'b1;
                        if (state == HEADER) begin
                            hdr_idx <= hdr_idx + 1'b1;
                            if (hdr_idx == HDR_IDX_W'(HDR_WORDS - 1)) begin
                                state <= DATA;
                            end
                        end
                        if (burst_left == BURST_W'(1)) begin
                            if (rec_left == len_t'(1)) begin
                                state         <= IDLE;
                                o_av_write    <= 1'b0;
                                o_record_done <= 1'b1;
                                rec_addr      <= burst_end_addr;   // packed records
                            end else begin
                                // next burst starts right behind this one
                                o_av_address    <= burst_end_addr;
                                o_av_burstcount <= burst_size(rec_left - 1'b1);
                                burst_left      <= burst_size(rec_left - 1'b1);
                            end
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rx_packet_framer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_packet_framer (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               i_rx_valid,
    input  wire                               i_rx_first,
    input  wire                               i_rx_last,
    input  wire  [2:0]                        i_rx_last_bytes,
    input  wire  [pkt_capture_pkg::DATA_W-1:0] i_rx_data,
    input  wire  [31:0]                       i_sec,
    input  wire  [31:0]                       i_nsec,
    fifo_port_if.writer                       data_port,
    fifo_port_if.writer                       desc_port,
    output logic [15:0]                       o_drop_count
);

    import pkt_capture_pkg::*;

    logic        keep_pkt;      // decision held for the rest of the packet
    len_t        word_cnt;
    logic [31:0] ts_sec;
    logic [31:0] ts_nsec;
    int          data_fill;
    int          desc_fill;
    logic        room_ok;
    logic        keep_word;
    len_t        cur_words;
    len_t        byte_len;
    pkt_desc_t   desc_next;

    always_comb begin
        // occupancy includes the entry still sitting in the push register
        data_fill = int'(data_port.used) + int'(data_port.push);
        desc_fill = int'(desc_port.used) + int'(desc_port.push);
        room_ok   = (data_fill + MAX_PKT_WORDS <= DATA_FIFO_DEPTH) &&
                    (desc_fill < DESC_FIFO_DEPTH);
        keep_word = i_rx_first ? room_ok : keep_pkt;
        cur_words = i_rx_first ? len_t'(1) : word_cnt + 1'b1;
        byte_len  = (cur_words << 2) - len_t'(3'd4 - i_rx_last_bytes);

        desc_next.length = byte_len;
        desc_next.sec    = i_rx_first ? i_sec : ts_sec;   // one-word packet
        desc_next.nsec   = i_rx_first ? i_nsec : ts_nsec;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            keep_pkt       <= 1'b0;
            word_cnt       <= '0;
            o_drop_count   <= '0;
            data_port.push <= 1'b0;
            desc_port.push <= 1'b0;
        end else begin
            data_port.push <= i_rx_valid && keep_word;
            desc_port.push <= i_rx_valid && i_rx_last && keep_word;
            if (i_rx_valid) begin
                word_cnt <= cur_words;
                if (i_rx_first) begin
                    keep_pkt <= room_ok;
                    if (!room_ok) begin
                        o_drop_count <= o_drop_count + 1'b1;  // whole packet goes
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        data_port.push_data <= i_rx_data;
        desc_port.push_data <= desc_next;
        if (i_rx_valid && i_rx_first) begin
            ts_sec  <= i_sec;   // time of the first word
            ts_nsec <= i_nsec;
        end
    end

endmodule

`default_nettype wire

// File: word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 64
) (
    input wire        clk,
    input wire        reset,
    fifo_port_if.fifo port_if
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = port_if.push && !port_if.full;
    assign do_pop  = port_if.pop && !port_if.empty;

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= port_if.push_data;
        end
    end

    // show-ahead read, head follows rd_ptr
    assign port_if.head  = mem[rd_ptr];
    assign port_if.empty = (count == '0);
    assign port_if.full  = (count == CNT_W'(DEPTH));
    assign port_if.used  = count;

endmodule

`default_nettype wire

// File: timestamp_counter.sv
`timescale 1ns/1ps
`default_nettype none

module timestamp_counter (
    input  wire         clk,
    input  wire         reset,
    input  wire         i_set,
    input  wire  [31:0] i_sec,
    input  wire  [31:0] i_nsec,
    output logic [31:0] o_sec,
    output logic [31:0] o_nsec
);

    import pkt_capture_pkg::*;

    logic [31:0] nsec_inc;
    logic        sec_wrap;

    assign nsec_inc = o_nsec + 32'(NS_PER_CYCLE);
    assign sec_wrap = (nsec_inc >= 32'(NS_PER_SEC));

    always_ff @(posedge clk) begin
        if (!reset) begin
            o_sec  <= '0;
            o_nsec <= '0;
        end else if (i_set) begin
            o_sec  <= i_sec;    // loaded value shows on the next cycle
            o_nsec <= i_nsec;
        end else if (sec_wrap) begin
            o_sec  <= o_sec + 1'b1;
            o_nsec <= nsec_inc - 32'(NS_PER_SEC);   // zero for aligned values
        end else begin
            o_nsec <= nsec_inc;
        end
    end

endmodule

`default_nettype wire

// File: fifo_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_port_if #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 64
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             push;       // one-cycle strobe, ignored when full
    payload_t         push_data;
    logic             pop;        // one-cycle strobe, ignored when empty
    payload_t         head;       // oldest entry, valid while !empty
    logic             empty;
    logic             full;
    logic [CNT_W-1:0] used;

    modport writer (output push, output push_data, input empty, input full, input used);

    modport reader (output pop, input head, input empty, input full, input used);

    modport fifo (
        input  push, push_data, pop,
        output head, empty, full, used
    );

endinterface

`default_nettype wire

// File: pkt_capture_pkg.sv
`default_nettype none

package pkt_capture_pkg;

    localparam int DATA_W          = 32;              // data and address width
    localparam int MAX_PKT_BYTES   = 64;
    localparam int MAX_PKT_WORDS   = MAX_PKT_BYTES / 4;
    localparam int HDR_WORDS       = 4;               // sec, nsec, len, len
    localparam int BURST_MAX       = 4;               // words per burst
    localparam int BURST_W         = $clog2(BURST_MAX + 1);
    localparam int DATA_FIFO_DEPTH = 64;
    localparam int DESC_FIFO_DEPTH = 8;
    localparam int NS_PER_CYCLE    = 20;              // 50 MHz clock
    localparam int NS_PER_SEC      = 1_000_000_000;

    typedef logic [15:0] len_t;                       // byte length

    // one entry per captured packet, 80 bits
    typedef struct packed {
        len_t        length;
        logic [31:0] sec;
        logic [31:0] nsec;
    } pkt_desc_t;

endpackage

`default_nettype wire
